// ==== source/sdram_pkg.sv ====
package sdram_pkg;

    // geometry
    localparam int USER_ADDR_W = 23;
    localparam int DATA_W      = 32;
    localparam int ROW_W       = 13;
    localparam int BANK_W      = 2;
    localparam int NUM_BANKS   = 4;
    localparam int COL_W       = 8;
    localparam int COL_HI_W    = 6;
    localparam int COL_LO_W    = 2;

    // timing in clock cycles
    localparam int T_RP             = 3;
    localparam int T_RCD            = 3;
    localparam int T_RFC            = 7;
    localparam int CAS_LATENCY      = 3;
    localparam int REFRESH_INTERVAL = 750;
    localparam int REF_CNT_W        = $clog2(REFRESH_INTERVAL);
    // wide enough for the longest wait load (T_RFC - 2)
    localparam int WAIT_W           = 3;

    // command word is {cs, ras, cas, we}
    localparam int CMD_W = 4;
    localparam logic [CMD_W-1:0] CMD_NOP       = 4'b0111;
    localparam logic [CMD_W-1:0] CMD_ACTIVE    = 4'b0011;
    localparam logic [CMD_W-1:0] CMD_READ      = 4'b0101;
    localparam logic [CMD_W-1:0] CMD_WRITE     = 4'b0100;
    localparam logic [CMD_W-1:0] CMD_PRECHARGE = 4'b0010;
    localparam logic [CMD_W-1:0] CMD_REFRESH   = 4'b0001;

    // sequencer state codes
    localparam int ST_W = 3;
    localparam logic [ST_W-1:0] ST_IDLE      = 3'd0;
    localparam logic [ST_W-1:0] ST_PRECHARGE = 3'd1;
    localparam logic [ST_W-1:0] ST_ACTIVATE  = 3'd2;
    localparam logic [ST_W-1:0] ST_READ      = 3'd3;
    localparam logic [ST_W-1:0] ST_WRITE     = 3'd4;
    localparam logic [ST_W-1:0] ST_REFRESH   = 3'd5;
    localparam logic [ST_W-1:0] ST_WAIT      = 3'd6;

    // user address, raw word or remapped fields
    // bank comes from bits 3:2 so consecutive words spread over banks
    typedef union packed {
        logic [USER_ADDR_W-1:0] raw;
        struct packed {
            logic [ROW_W-1:0]    row;
            logic [COL_HI_W-1:0] col_hi;
            logic [BANK_W-1:0]   bank;
            logic [COL_LO_W-1:0] col_lo;
        } f;
    } user_addr_u;

endpackage

// ==== source/request_queue.sv ====
`timescale 1ns/100ps

module request_queue (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              in_valid,
    input  logic                              rw,
    input  logic [sdram_pkg::USER_ADDR_W-1:0] user_addr,
    input  logic [sdram_pkg::DATA_W-1:0]      data_in,
    input  logic                              req_take,
    output logic                              busy,
    output logic                              req_pending,
    output logic                              req_rw,
    output sdram_pkg::user_addr_u             req_addr,
    output logic [sdram_pkg::DATA_W-1:0]      req_data
);
    import sdram_pkg::*;

    logic full_q;

    // accept only into an empty entry
    always_ff @(posedge clk) begin
        if (rst) begin
            full_q <= 1'b0;
        end else if (in_valid && !full_q) begin
            full_q <= 1'b1;
        end else if (req_take) begin
            full_q <= 1'b0;
        end
    end

    // payload, raw word in, field view out
    always_ff @(posedge clk) begin
        if (in_valid && !full_q) begin
            req_rw       <= rw;
            req_addr.raw <= user_addr;
            req_data     <= data_in;
        end
    end

    assign busy        = full_q;
    assign req_pending = full_q;

    // sequencer only takes a stored request
    a_take_needs_entry: assert property (@(posedge clk) disable iff (rst)
        req_take |-> full_q);

endmodule

// ==== source/refresh_timer.sv ====
`timescale 1ns/100ps

module refresh_timer (
    input  logic clk,
    input  logic rst,
    input  logic ref_ack,
    output logic ref_pending
);
    import sdram_pkg::*;

    logic [REF_CNT_W-1:0] cnt_q;
    logic                 wrap;

    // one refresh request per interval
    assign wrap = (cnt_q == REF_CNT_W'(REFRESH_INTERVAL - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q       <= '0;
            ref_pending <= 1'b0;
        end else begin
            cnt_q <= wrap ? '0 : cnt_q + 1'b1;
            // a new interval wins over a late ack
            if (wrap) begin
                ref_pending <= 1'b1;
            end else if (ref_ack) begin
                ref_pending <= 1'b0;
            end
        end
    end

    // ack from the sequencer only answers a raised flag
    a_ack_while_pending: assert property (@(posedge clk) disable iff (rst)
        ref_ack |-> ref_pending);

endmodule

// ==== source/bank_tracker.sv ====
`timescale 1ns/100ps

module bank_tracker (
    input  logic                  clk,
    input  logic                  rst,
    input  sdram_pkg::user_addr_u req_addr,
    input  logic                  act_en,
    input  sdram_pkg::user_addr_u act_addr,
    input  logic                  precharge_en,
    input  logic                  precharge_all,
    output logic                  row_open,
    output logic                  row_hit
);
    import sdram_pkg::*;

    // open flag per bank, row number per bank
    logic [NUM_BANKS-1:0] open_q;
    logic [ROW_W-1:0]     row_q [NUM_BANKS];

    // lookup for the queued request
    assign row_open = open_q[req_addr.f.bank];
    assign row_hit  = row_open && (row_q[req_addr.f.bank] == req_addr.f.row);

    always_ff @(posedge clk) begin
        if (rst) begin
            // all rows closed out of reset
            open_q <= '0;
        end else if (precharge_en) begin
            if (precharge_all) begin
                open_q <= '0;
            end else begin
                // single bank, taken from the latched access
                open_q[act_addr.f.bank] <= 1'b0;
            end
        end else if (act_en) begin
            open_q[act_addr.f.bank] <= 1'b1;
        end
    end

    // row number per bank, written on activate
    always_ff @(posedge clk) begin
        if (act_en) begin
            row_q[act_addr.f.bank] <= act_addr.f.row;
        end
    end

endmodule

// ==== source/cmd_sequencer.sv ====
`timescale 1ns/100ps

module cmd_sequencer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req_pending,
    input  logic                         req_rw,
    input  sdram_pkg::user_addr_u        req_addr,
    input  logic [sdram_pkg::DATA_W-1:0] req_data,
    input  logic                         ref_pending,
    input  logic                         row_open,
    input  logic                         row_hit,
    output logic                         req_take,
    output logic                         ref_ack,
    output logic                         act_en,
    output sdram_pkg::user_addr_u        act_addr,
    output logic                         precharge_en,
    output logic                         precharge_all,
    output logic [sdram_pkg::CMD_W-1:0]  cmd,
    output logic [sdram_pkg::BANK_W-1:0] ba,
    output logic [sdram_pkg::ROW_W-1:0]  a,
    output logic [sdram_pkg::DATA_W-1:0] wr_data,
    output logic                         wr_en,
    output logic                         rd_capture
);
    import sdram_pkg::*;

    logic [ST_W-1:0]   state_q;
    logic [ST_W-1:0]   ret_q;
    logic [WAIT_W-1:0] wait_q;
    logic              pre_all_q;
    // latched access, frees the queue for the next request
    user_addr_u        addr_q;
    logic              rw_q;
    logic [DATA_W-1:0] data_q;
    logic [ROW_W-1:0]  col_a;
    logic [ST_W-1:0]   rw_state;

    // column shifted left by two, A10 stays low
    assign col_a    = {{(ROW_W - COL_W - 2){1'b0}}, addr_q.f.col_hi, addr_q.f.col_lo, 2'b00};
    assign rw_state = rw_q ? ST_WRITE : ST_READ;
    assign act_addr = addr_q;
    assign wr_data  = data_q;

    // command decided here, shown at the pins one cycle later
    always_comb begin
        req_take      = 1'b0;
        ref_ack       = 1'b0;
        act_en        = 1'b0;
        precharge_en  = 1'b0;
        precharge_all = 1'b0;
        cmd           = CMD_NOP;
        ba            = addr_q.f.bank;
        a             = '0;
        wr_en         = 1'b0;
        rd_capture    = 1'b0;
        case (state_q)
            ST_IDLE: begin
                // refresh goes ahead of user traffic
                ref_ack  = ref_pending;
                req_take = !ref_pending && req_pending;
            end
            ST_PRECHARGE: begin
                cmd           = CMD_PRECHARGE;
                // A10 selects all banks
                a[10]         = pre_all_q;
                precharge_en  = 1'b1;
                precharge_all = pre_all_q;
            end
            ST_ACTIVATE: begin
                cmd    = CMD_ACTIVE;
                a      = addr_q.f.row;
                act_en = 1'b1;
            end
            ST_READ: begin
                cmd        = CMD_READ;
                a          = col_a;
                rd_capture = 1'b1;
            end
            ST_WRITE: begin
                cmd   = CMD_WRITE;
                a     = col_a;
                wr_en = 1'b1;
            end
            ST_REFRESH: begin
                cmd = CMD_REFRESH;
            end
            default: begin
                cmd = CMD_NOP;
            end
        endcase
    end

    // wait loads are two short, one cycle each for the command and the exit
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= ST_IDLE;
            ret_q     <= ST_IDLE;
            wait_q    <= '0;
            pre_all_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (ref_ack) begin
                        pre_all_q <= 1'b1;
                        state_q   <= ST_PRECHARGE;
                        ret_q     <= ST_REFRESH;
                    end else if (req_take) begin
                        if (row_hit) begin
                            state_q <= req_rw ? ST_WRITE : ST_READ;
                        end else if (row_open) begin
                            // conflict, close the old row first
                            pre_all_q <= 1'b0;
                            state_q   <= ST_PRECHARGE;
                            ret_q     <= ST_ACTIVATE;
                        end else begin
                            state_q <= ST_ACTIVATE;
                        end
                    end
                end
                ST_PRECHARGE: begin
                    wait_q  <= WAIT_W'(T_RP - 2);
                    state_q <= ST_WAIT;
                end
                ST_ACTIVATE: begin
                    wait_q  <= WAIT_W'(T_RCD - 2);
                    ret_q   <= rw_state;
                    state_q <= ST_WAIT;
                end
                ST_READ: begin
                    // hold off until the data is back
                    wait_q  <= WAIT_W'(CAS_LATENCY - 1);
                    ret_q   <= ST_IDLE;
                    state_q <= ST_WAIT;
                end
                ST_REFRESH: begin
                    wait_q  <= WAIT_W'(T_RFC - 2);
                    ret_q   <= ST_IDLE;
                    state_q <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (wait_q == '0) begin
                        state_q <= ret_q;
                    end else begin
                        wait_q <= wait_q - 1'b1;
                    end
                end
                default: begin
                    // write needs no recovery here
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_take) begin
            addr_q <= req_addr;
            rw_q   <= req_rw;
            data_q <= req_data;
        end
    end

    // column access only into an open, matching row of the tracker
    a_rw_on_hit: assert property (@(posedge clk) disable iff (rst)
        ((cmd == CMD_READ || cmd == CMD_WRITE)
            && req_addr.f.bank == addr_q.f.bank
            && req_addr.f.row == addr_q.f.row) |-> row_hit);

endmodule

// ==== source/sdram_pins.sv ====
`timescale 1ns/100ps

module sdram_pins (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [sdram_pkg::CMD_W-1:0]  cmd,
    input  logic [sdram_pkg::BANK_W-1:0] ba,
    input  logic [sdram_pkg::ROW_W-1:0]  a,
    input  logic [sdram_pkg::DATA_W-1:0] wr_data,
    input  logic                         wr_en,
    input  logic                         rd_capture,
    input  logic [sdram_pkg::DATA_W-1:0] sdram_dq_in,
    output logic                         sdram_cke,
    output logic                         sdram_cs,
    output logic                         sdram_ras,
    output logic                         sdram_cas,
    output logic                         sdram_we,
    output logic [sdram_pkg::BANK_W-1:0] sdram_ba,
    output logic [sdram_pkg::ROW_W-1:0]  sdram_a,
    output logic [sdram_pkg::DATA_W-1:0] sdram_dq_out,
    output logic                         sdram_dq_oe,
    output logic [sdram_pkg::DATA_W-1:0] data_out,
    output logic                         out_valid
);
    import sdram_pkg::*;

    logic [CMD_W-1:0]       cmd_q;
    // bit 0 lines up with READ at the pins
    logic [CAS_LATENCY:0]   rd_pipe;
    logic [DATA_W-1:0]      dq_in_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            sdram_cke   <= 1'b0;
            cmd_q       <= CMD_NOP;
            sdram_dq_oe <= 1'b0;
            rd_pipe     <= '0;
            out_valid   <= 1'b0;
        end else begin
            // clock enable rises on the first edge out of reset
            sdram_cke   <= 1'b1;
            cmd_q       <= cmd;
            sdram_dq_oe <= wr_en;
            rd_pipe     <= {rd_pipe[CAS_LATENCY-1:0], rd_capture};
            out_valid   <= rd_pipe[CAS_LATENCY];
        end
    end

    always_ff @(posedge clk) begin
        sdram_ba     <= ba;
        sdram_a      <= a;
        sdram_dq_out <= wr_data;
        // sample CAS_LATENCY edges after READ at the pins
        if (rd_pipe[CAS_LATENCY-1]) begin
            dq_in_q <= sdram_dq_in;
        end
        // present one cycle later with the valid pulse
        if (rd_pipe[CAS_LATENCY]) begin
            data_out <= dq_in_q;
        end
    end

    // command word split onto the control pins
    assign sdram_cs  = cmd_q[3];
    assign sdram_ras = cmd_q[2];
    assign sdram_cas = cmd_q[1];
    assign sdram_we  = cmd_q[0];

endmodule

// ==== source/sdram_ctrl_top.sv ====
`timescale 1ns/100ps

module sdram_ctrl_top (
    input  logic                              clk,
    input  logic                              rst,
    // user side
    input  logic                              in_valid,
    input  logic                              rw,
    input  logic [sdram_pkg::USER_ADDR_W-1:0] user_addr,
    input  logic [sdram_pkg::DATA_W-1:0]      data_in,
    output logic                              busy,
    output logic                              out_valid,
    output logic [sdram_pkg::DATA_W-1:0]      data_out,
    // sdram pins
    output logic                              sdram_cke,
    output logic                              sdram_cs,
    output logic                              sdram_ras,
    output logic                              sdram_cas,
    output logic                              sdram_we,
    output logic [sdram_pkg::BANK_W-1:0]      sdram_ba,
    output logic [sdram_pkg::ROW_W-1:0]       sdram_a,
    output logic [sdram_pkg::DATA_W-1:0]      sdram_dq_out,
    output logic                              sdram_dq_oe,
    input  logic [sdram_pkg::DATA_W-1:0]      sdram_dq_in
);
    import sdram_pkg::*;

    // queue to sequencer
    logic              req_pending;
    logic              req_rw;
    user_addr_u        req_addr;
    logic [DATA_W-1:0] req_data;
    logic              req_take;
    // refresh handshake
    logic              ref_pending;
    logic              ref_ack;
    // bank table lookup and updates
    logic              row_open;
    logic              row_hit;
    logic              act_en;
    user_addr_u        act_addr;
    logic              precharge_en;
    logic              precharge_all;
    // sequencer to pin stage
    logic [CMD_W-1:0]  cmd;
    logic [BANK_W-1:0] ba;
    logic [ROW_W-1:0]  a;
    logic [DATA_W-1:0] wr_data;
    logic              wr_en;
    logic              rd_capture;

    request_queue u_queue (
        .clk(clk), .rst(rst), .in_valid(in_valid), .rw(rw), .user_addr(user_addr),
        .data_in(data_in), .req_take(req_take), .busy(busy), .req_pending(req_pending),
        .req_rw(req_rw), .req_addr(req_addr), .req_data(req_data)
    );

    refresh_timer u_refresh (
        .clk(clk), .rst(rst), .ref_ack(ref_ack), .ref_pending(ref_pending)
    );

    bank_tracker u_banks (
        .clk(clk), .rst(rst), .req_addr(req_addr), .act_en(act_en), .act_addr(act_addr),
        .precharge_en(precharge_en), .precharge_all(precharge_all),
        .row_open(row_open), .row_hit(row_hit)
    );

    cmd_sequencer u_seq (
        .clk(clk), .rst(rst), .req_pending(req_pending), .req_rw(req_rw),
        .req_addr(req_addr), .req_data(req_data), .ref_pending(ref_pending),
        .row_open(row_open), .row_hit(row_hit), .req_take(req_take), .ref_ack(ref_ack),
        .act_en(act_en), .act_addr(act_addr), .precharge_en(precharge_en),
        .precharge_all(precharge_all), .cmd(cmd), .ba(ba), .a(a), .wr_data(wr_data),
        .wr_en(wr_en), .rd_capture(rd_capture)
    );

    sdram_pins u_pins (
        .clk(clk), .rst(rst), .cmd(cmd), .ba(ba), .a(a), .wr_data(wr_data), .wr_en(wr_en),
        .rd_capture(rd_capture), .sdram_dq_in(sdram_dq_in), .sdram_cke(sdram_cke),
        .sdram_cs(sdram_cs), .sdram_ras(sdram_ras), .sdram_cas(sdram_cas),
        .sdram_we(sdram_we), .sdram_ba(sdram_ba), .sdram_a(sdram_a),
        .sdram_dq_out(sdram_dq_out), .sdram_dq_oe(sdram_dq_oe), .data_out(data_out),
        .out_valid(out_valid)
    );

endmodule

// ==== bench/sdram_model.sv ====
`timescale 1ns/100ps

module sdram_model (
    input  logic                         clk,
    input  logic                         cke,
    input  logic                         cs,
    input  logic                         ras,
    input  logic                         cas,
    input  logic                         we,
    input  logic [sdram_pkg::BANK_W-1:0] ba,
    input  logic [sdram_pkg::ROW_W-1:0]  a,
    input  logic [sdram_pkg::DATA_W-1:0] dq_out,
    input  logic                         dq_oe,
    output logic [sdram_pkg::DATA_W-1:0] dq_in
);
    import sdram_pkg::*;

    // storage keyed by {bank, row, column}
    logic [DATA_W-1:0] mem [logic [BANK_W+ROW_W+COL_W-1:0]];
    logic [ROW_W-1:0]  open_row [NUM_BANKS];
    logic [CMD_W-1:0]  cmd;
    logic [CMD_W-1:0]  prev_cmd;
    logic              prev_a10;
    logic [DATA_W-1:0] rd_stage;
    logic [BANK_W+ROW_W+COL_W-1:0] key;

    // command counters and the last bank and address per kind
    int n_act = 0;
    int n_pre = 0;
    int n_read = 0;
    int n_write = 0;
    int n_ref = 0;
    int n_ref_after_pre_all = 0;
    logic [BANK_W-1:0] act_ba;
    logic [ROW_W-1:0]  act_a;
    logic [BANK_W-1:0] rw_ba;
    logic [ROW_W-1:0]  rw_a;

    assign cmd = {cs, ras, cas, we};
    // column sits in a[9:2]
    assign key = {ba, open_row[ba], a[9:2]};

    initial begin
        prev_cmd = CMD_NOP;
        prev_a10 = 1'b0;
        rd_stage = '0;
        dq_in    = '0;
    end

    always @(posedge clk) begin
        // two stages here plus the controller's register make CAS_LATENCY
        dq_in <= rd_stage;
        if (cke && cmd == CMD_READ) begin
            n_read <= n_read + 1;
            rw_ba  <= ba;
            rw_a   <= a;
            // unwritten words return a pattern of the whole key
            rd_stage <= mem.exists(key) ? mem[key] : ({9'h0, key} ^ 32'hc3a5_0f1e);
        end else begin
            rd_stage <= 'x;
        end
        if (cke && cmd == CMD_WRITE) begin
            n_write <= n_write + 1;
            rw_ba   <= ba;
            rw_a    <= a;
            if (dq_oe) begin
                mem[key] = dq_out;
            end
        end
        if (cke && cmd == CMD_ACTIVE) begin
            n_act        <= n_act + 1;
            act_ba       <= ba;
            act_a        <= a;
            open_row[ba] <= a;
        end
        if (cke && cmd == CMD_PRECHARGE) begin
            n_pre <= n_pre + 1;
        end
        if (cke && cmd == CMD_REFRESH) begin
            n_ref <= n_ref + 1;
            if (prev_cmd == CMD_PRECHARGE && prev_a10) begin
                n_ref_after_pre_all <= n_ref_after_pre_all + 1;
            end
        end
        // remember the last real command
        if (cke && cmd != CMD_NOP) begin
            prev_cmd <= cmd;
            prev_a10 <= a[10];
        end
    end

endmodule

// ==== bench/tb_sdram_ctrl.sv ====
`timescale 1ns/100ps

module tb_sdram_ctrl;
    import sdram_pkg::*;

    localparam int N_ENT = 10;
    localparam int LIMIT = 300;

    logic              clk;
    logic              rst;
    logic              in_valid;
    logic              rw;
    logic [22:0]       user_addr;
    logic [31:0]       data_in;
    logic              busy;
    logic              out_valid;
    logic [31:0]       data_out;
    logic              sdram_cke;
    logic              sdram_cs;
    logic              sdram_ras;
    logic              sdram_cas;
    logic              sdram_we;
    logic [1:0]        sdram_ba;
    logic [12:0]       sdram_a;
    logic [31:0]       sdram_dq_out;
    logic              sdram_dq_oe;
    logic [31:0]       sdram_dq_in;

    // stimulus table with expected read data and command deltas
    logic        tbl_rw   [N_ENT];
    logic [22:0] tbl_addr [N_ENT];
    logic [31:0] tbl_data [N_ENT];
    logic [31:0] tbl_exp  [N_ENT];
    int          tbl_act  [N_ENT];
    int          tbl_pre  [N_ENT];
    logic [31:0] shadow   [logic [22:0]];

    int checks = 0;
    int errors = 0;
    int pulses = 0;
    int err0;
    int ref0;
    int ref_all0;

    sdram_ctrl_top u_dut (
        .clk(clk), .rst(rst), .in_valid(in_valid), .rw(rw), .user_addr(user_addr),
        .data_in(data_in), .busy(busy), .out_valid(out_valid), .data_out(data_out),
        .sdram_cke(sdram_cke), .sdram_cs(sdram_cs), .sdram_ras(sdram_ras),
        .sdram_cas(sdram_cas), .sdram_we(sdram_we), .sdram_ba(sdram_ba),
        .sdram_a(sdram_a), .sdram_dq_out(sdram_dq_out), .sdram_dq_oe(sdram_dq_oe),
        .sdram_dq_in(sdram_dq_in)
    );

    sdram_model u_model (
        .clk(clk), .cke(sdram_cke), .cs(sdram_cs), .ras(sdram_ras), .cas(sdram_cas),
        .we(sdram_we), .ba(sdram_ba), .a(sdram_a), .dq_out(sdram_dq_out),
        .dq_oe(sdram_dq_oe), .dq_in(sdram_dq_in)
    );

    always #2 clk = ~clk;

    // cycles with out_valid high, sampled mid-cycle
    always @(negedge clk) begin
        if (out_valid) begin
            pulses = pulses + 1;
        end
    end

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL at %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // address from row, bank and 8-bit column
    function automatic logic [22:0] make_addr(input int row, input int bank, input int col);
        logic [12:0] r;
        logic [1:0]  b;
        logic [7:0]  c;
        r = row[12:0];
        b = bank[1:0];
        c = col[7:0];
        return {r, c[7:2], b, c[1:0]};
    endfunction

    // model key {bank, row, column} for a user address
    function automatic logic [22:0] key_of(input logic [22:0] addr);
        return {addr[3:2], addr[22:10], addr[9:4], addr[1:0]};
    endfunction

    task automatic wait_busy_low();
        int n;
        n = 0;
        while (busy && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            errors++;
            $display("timeout: busy stayed high");
        end
    endtask

    task automatic wait_out_valid();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!out_valid && n < LIMIT);
        if (!out_valid) begin
            errors++;
            $display("timeout: no out_valid for a read");
        end
    endtask

    task automatic wait_writes(input int target);
        int n;
        n = 0;
        while (u_model.n_write < target && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (u_model.n_write < target) begin
            errors++;
            $display("timeout: write never reached the memory");
        end
    endtask

    task automatic add_entry(input int i, input logic w, input logic [22:0] addr,
                             input int act, input int pre);
        tbl_rw[i]   = w;
        tbl_addr[i] = addr;
        tbl_act[i]  = act;
        tbl_pre[i]  = pre;
        tbl_data[i] = $urandom;
        if (w) begin
            shadow[addr] = tbl_data[i];
        end
        tbl_exp[i] = shadow.exists(addr) ? shadow[addr] : 32'h0;
    endtask

    task automatic run_entry(input int i);
        int act0;
        int pre0;
        int wr0;
        int rd0;
        int p0;
        logic [12:0] col_exp;
        act0 = u_model.n_act;
        pre0 = u_model.n_pre;
        wr0  = u_model.n_write;
        rd0  = u_model.n_read;
        p0   = pulses;
        err0 = errors;
        wait_busy_low();
        in_valid  = 1'b1;
        rw        = tbl_rw[i];
        user_addr = tbl_addr[i];
        data_in   = tbl_data[i];
        @(negedge clk);
        in_valid = 1'b0;
        check("request accepted", busy, 1'b1);
        if (tbl_rw[i]) begin
            wait_writes(wr0 + 1);
            // a stray read pulse would have shown by now
            repeat (CAS_LATENCY + 1) @(negedge clk);
            check("no pulse on write", pulses, p0);
        end else begin
            wait_out_valid();
            check("read data", data_out, tbl_exp[i]);
            // second edge also counts a pulse that stays high
            repeat (2) @(negedge clk);
            check("one pulse per read", pulses, p0 + 1);
        end
        check("read commands", u_model.n_read - rd0, tbl_rw[i] ? 0 : 1);
        check("write commands", u_model.n_write - wr0, tbl_rw[i] ? 1 : 0);
        check("activate count", u_model.n_act - act0, tbl_act[i]);
        check("precharge count", u_model.n_pre - pre0, tbl_pre[i]);
        if (tbl_act[i] != 0) begin
            check("activate bank", u_model.act_ba, tbl_addr[i][3:2]);
            check("activate row", u_model.act_a, tbl_addr[i][22:10]);
        end
        // column shifted by two, A10 low
        col_exp = {3'b000, tbl_addr[i][9:4], tbl_addr[i][1:0], 2'b00};
        check("column bank", u_model.rw_ba, tbl_addr[i][3:2]);
        check("column address", u_model.rw_a, col_exp);
        $display("entry %0d %s: %0d errors", i, tbl_rw[i] ? "write" : "read", errors - err0);
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        rw        = 1'b0;
        user_addr = '0;
        data_in   = '0;
        void'($urandom(32'h9c38));

        // bank 1 hits and conflicts, bank 2 from idle
        add_entry(0, 1'b1, make_addr(5, 1, 8'h3d), 1, 0);
        add_entry(1, 1'b0, make_addr(5, 1, 8'h3d), 0, 0);
        add_entry(2, 1'b1, make_addr(5, 1, 8'hc2), 0, 0);
        add_entry(3, 1'b1, make_addr(9, 1, 8'h11), 1, 1);
        add_entry(4, 1'b0, make_addr(5, 1, 8'h3d), 1, 1);
        add_entry(5, 1'b1, make_addr(2, 2, 8'h7f), 1, 0);
        add_entry(6, 1'b0, make_addr(9, 1, 8'h11), 1, 1);
        add_entry(7, 1'b0, make_addr(2, 2, 8'h7f), 0, 0);
        add_entry(8, 1'b0, make_addr(5, 1, 8'hc2), 1, 1);
        // after refresh every bank is closed
        add_entry(9, 1'b0, make_addr(2, 2, 8'h7f), 1, 0);

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        err0 = errors;
        check("busy after reset", busy, 1'b0);
        check("out_valid after reset", out_valid, 1'b0);
        check("dq_oe after reset", sdram_dq_oe, 1'b0);
        check("pins after reset", {sdram_cs, sdram_ras, sdram_cas, sdram_we}, CMD_NOP);
        check("cke after reset", sdram_cke, 1'b1);
        $display("reset state: %0d errors", errors - err0);

        for (int i = 0; i < N_ENT - 1; i++) begin
            run_entry(i);
        end

        // idle long enough for one refresh
        ref0     = u_model.n_ref;
        ref_all0 = u_model.n_ref_after_pre_all;
        repeat (800) @(negedge clk);
        err0 = errors;
        check("refresh after precharge all", u_model.n_ref_after_pre_all > ref_all0, 1'b1);
        check("refresh only after precharge all", u_model.n_ref - ref0,
              u_model.n_ref_after_pre_all - ref_all0);
        $display("refresh: %0d errors", errors - err0);
        run_entry(N_ENT - 1);

        // A accepted, C held while busy, B after busy falls
        err0 = errors;
        ref0 = u_model.n_write;
        wait_busy_low();
        in_valid  = 1'b1;
        rw        = 1'b1;
        user_addr = make_addr(40, 3, 8'h05);
        data_in   = 32'haaaa_0001;
        @(negedge clk);
        user_addr = make_addr(41, 3, 8'h06);
        data_in   = 32'hcccc_0003;
        wait_busy_low();
        user_addr = make_addr(42, 3, 8'h07);
        data_in   = 32'hbbbb_0002;
        @(negedge clk);
        in_valid = 1'b0;
        wait_writes(ref0 + 2);
        repeat (20) @(negedge clk);
        check("write count", u_model.n_write - ref0, 2);
        check("first word", u_model.mem[key_of(make_addr(40, 3, 8'h05))], 32'haaaa_0001);
        check("held word ignored", u_model.mem.exists(key_of(make_addr(41, 3, 8'h06))), 1'b0);
        check("word after busy", u_model.mem[key_of(make_addr(42, 3, 8'h07))], 32'hbbbb_0002);
        $display("back-pressure: %0d errors", errors - err0);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== src.f ====
source/sdram_pkg.sv
source/request_queue.sv
source/refresh_timer.sv
source/bank_tracker.sv
source/cmd_sequencer.sv
source/sdram_pins.sv
source/sdram_ctrl_top.sv
bench/sdram_model.sv
bench/tb_sdram_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the SDRAM controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sdram_ctrl -f src.f -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
grep -q "TEST RESULT: PASS" sim.log
